//--- Makefile
# Verilator build and run of the beamformer testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module beam_tb -f all.f -Mdir obj_dir
	@out="$$(./obj_dir/Vbeam_tb)"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- all.f
common/beam_pkg.sv
rtl/tap_window.sv
fir_lane/fir_lane.sv
rtl/beam_combiner.sv
rtl/beam_top.sv
verification/beam_checker.sv
verification/beam_tb.sv

//--- common/beam_pkg.sv
/*
 * Beamformer shared definitions
 * Sizes, pipeline latencies and the packed structs that carry samples,
 * coefficient writes, lane operands and lane results
 */
package beam_pkg;

   // ==============================
   // Sizes
   // ==============================
   localparam int data_width   = 16;
   localparam int num_channels = 4;
   localparam int num_taps     = 4;

   // Index widths of the coefficient write port
   localparam int chan_idx_width = $clog2(num_channels);
   localparam int tap_idx_width  = $clog2(num_taps);

   // ==============================
   // Latencies in clock cycles
   // ==============================
   // Sample strobe to operands at the lanes
   localparam int window_latency  = 1;
   // Register, multiply, pair sums, final sum
   localparam int lane_latency    = 4;
   // Pair sums, then final sum
   localparam int combine_latency = 2;
   // Sample strobe to beam output
   localparam int total_latency   = window_latency + lane_latency + combine_latency;

   // ==============================
   // Types
   // ==============================
   // One data word, used for samples, coefficients and results alike
   typedef logic [data_width-1:0] word_t;

   // One sample per channel, all taken on the same strobe
   typedef struct packed {
      word_t [num_channels-1:0] ch;
   } sample_t;

   // Single coefficient write, lands in bank[channel][tap]
   typedef struct packed {
      logic [chan_idx_width-1:0] channel;
      logic [tap_idx_width-1:0]  tap;
      word_t                     value;
   } coef_wr_t;

   // Operands of one lane
   // sample[k] pairs with coef[k], tap 0 holds the newest sample
   typedef struct packed {
      word_t [num_taps-1:0] sample;
      word_t [num_taps-1:0] coef;
   } lane_ops_t;

   typedef lane_ops_t [num_channels-1:0] lane_ops_array_t;

   // One lane output per channel
   typedef word_t [num_channels-1:0] lane_result_array_t;

endpackage

//--- fir_lane/fir_lane.sv
/*
 * FIR lane
 * Four-stage pipeline for one channel: operand register, tap products,
 * pair sums and final sum, all wrapping at data_width bits
 */
module fir_lane (
   input  logic                            clk,
   input  logic                            rst,
   input  beam_pkg::lane_ops_t             ops,
   input  logic                            ops_valid,
   output logic [beam_pkg::data_width-1:0] result,
   output logic                            result_valid
);

   // Stage 1, registered operands
   beam_pkg::lane_ops_t ops_r;

   // Stage 2, one product per tap
   beam_pkg::word_t [beam_pkg::num_taps-1:0] prod_r;

   // Stage 3, first adder level
   beam_pkg::word_t [beam_pkg::num_taps/2-1:0] pair_r;

   // Stage 4, tree output
   beam_pkg::word_t sum_r;

   // Valid bit per stage, bit 0 is the operand stage
   logic [beam_pkg::lane_latency-1:0] valid_r;

   // ==============================
   // Data pipeline
   // ==============================
   // Free running, valid_r says which result is real
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ops_r  <= '0;
         prod_r <= '0;
         pair_r <= '0;
         sum_r  <= '0;
      end else begin
         // Operand register
         ops_r <= ops;

         // Products keep only the low data_width bits
         for (int i = 0; i < beam_pkg::num_taps; i++) begin
            prod_r[i] <= ops_r.sample[i] * ops_r.coef[i];
         end

         // Adjacent taps summed in pairs
         for (int i = 0; i < beam_pkg::num_taps/2; i++) begin
            pair_r[i] <= prod_r[2*i] + prod_r[2*i+1];
         end

         // Final adder, carry out dropped
         sum_r <= pair_r[0] + pair_r[1];
      end
   end

   // ==============================
   // Valid delay line
   // ==============================
   // Shifts one stage per cycle alongside the data
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_r <= '0;
      end else begin
         valid_r <= {valid_r[beam_pkg::lane_latency-2:0], ops_valid};
      end
   end

   assign result       = sum_r;
   assign result_valid = valid_r[beam_pkg::lane_latency-1];

endmodule

//--- rtl/beam_combiner.sv
/*
 * Beam combiner
 * Sums the lane results through a two-level registered adder tree
 * into one wrapping beam sample
 */
module beam_combiner (
   input  logic                            clk,
   input  logic                            rst,
   input  beam_pkg::lane_result_array_t    results,
   input  logic                            results_valid,
   output logic [beam_pkg::data_width-1:0] beam,
   output logic                            beam_valid
);

   // First level, neighbouring lanes summed in pairs
   beam_pkg::word_t [beam_pkg::num_channels/2-1:0] pair_r;

   // Second level, the beam itself
   beam_pkg::word_t beam_r;

   // Valid bit per adder level
   logic [beam_pkg::combine_latency-1:0] valid_r;

   // ==============================
   // Adder tree
   // ==============================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pair_r <= '0;
         beam_r <= '0;
      end else begin
         // Lane pairs, overflow dropped
         for (int i = 0; i < beam_pkg::num_channels/2; i++) begin
            pair_r[i] <= results[2*i] + results[2*i+1];
         end
         // Final sum over all channels
         beam_r <= pair_r[0] + pair_r[1];
      end
   end

   // Valid follows the data through both levels
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_r <= '0;
      end else begin
         valid_r <= {valid_r[beam_pkg::combine_latency-2:0], results_valid};
      end
   end

   assign beam       = beam_r;
   assign beam_valid = valid_r[beam_pkg::combine_latency-1];

endmodule

//--- rtl/beam_top.sv
/*
 * Beamformer top
 * Tap window, one FIR lane per sensor channel and the combiner
 * that folds the lane results into a single beam
 */
module beam_top (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            sample_valid,
   input  beam_pkg::sample_t               samples,
   input  logic                            coef_wr_valid,
   input  beam_pkg::coef_wr_t              coef_wr,
   output logic [beam_pkg::data_width-1:0] beam,
   output logic                            beam_valid
);

   // Window to lanes
   beam_pkg::lane_ops_array_t ops;
   logic                      ops_valid;

   // Lanes to combiner
   beam_pkg::lane_result_array_t      results;
   // All lanes run in lockstep, only lane 0 feeds the combiner
   logic [beam_pkg::num_channels-1:0] lane_valid;

   // ==============================
   // Sample window and coefficients
   // ==============================
   tap_window u_window (
      .clk           (clk),
      .rst           (rst),
      .sample_valid  (sample_valid),
      .samples       (samples),
      .coef_wr_valid (coef_wr_valid),
      .coef_wr       (coef_wr),
      .ops           (ops),
      .ops_valid     (ops_valid)
   );

   // One lane per channel
   for (genvar ch = 0; ch < beam_pkg::num_channels; ch++) begin : g_lane
      fir_lane u_lane (
         .clk          (clk),
         .rst          (rst),
         .ops          (ops[ch]),
         .ops_valid    (ops_valid),
         .result       (results[ch]),
         .result_valid (lane_valid[ch])
      );
   end

   // ==============================
   // Channel sum
   // ==============================
   beam_combiner u_combiner (
      .clk           (clk),
      .rst           (rst),
      .results       (results),
      .results_valid (lane_valid[0]),
      .beam          (beam),
      .beam_valid    (beam_valid)
   );

endmodule

//--- rtl/tap_window.sv
/*
 * Tap window
 * Holds the last num_taps samples of every channel and the coefficient bank,
 * and hands one operand set per channel to the FIR lanes on each sample strobe
 */
module tap_window (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      sample_valid,
   input  beam_pkg::sample_t         samples,
   input  logic                      coef_wr_valid,
   input  beam_pkg::coef_wr_t        coef_wr,
   output beam_pkg::lane_ops_array_t ops,
   output logic                      ops_valid
);

   // Sample delay lines, tap 0 is the newest
   beam_pkg::word_t [beam_pkg::num_channels-1:0][beam_pkg::num_taps-1:0] window_r;

   // Coefficient bank as written through the write port
   beam_pkg::word_t [beam_pkg::num_channels-1:0][beam_pkg::num_taps-1:0] coef_r;

   // Bank copy taken with each sample
   // Stays stable while the window is held between strobes
   beam_pkg::word_t [beam_pkg::num_channels-1:0][beam_pkg::num_taps-1:0] coef_snap_r;

   // Marks the cycle in which the lanes should take the operands
   logic ops_valid_r;

   // ==============================
   // Sample delay lines
   // ==============================
   // Advances only on a strobe, idle cycles leave the window untouched
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         window_r <= '0;
      end else if (sample_valid) begin
         for (int c = 0; c < beam_pkg::num_channels; c++) begin
            // New sample enters at tap 0
            window_r[c][0] <= samples.ch[c];
            // Older samples move one tap down, the oldest drops out
            for (int t = 1; t < beam_pkg::num_taps; t++) begin
               window_r[c][t] <= window_r[c][t-1];
            end
         end
      end
   end

   // ==============================
   // Coefficient bank
   // ==============================
   // One word per write, addressed by channel and tap
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         coef_r <= '0;
      end else if (coef_wr_valid) begin
         coef_r[coef_wr.channel][coef_wr.tap] <= coef_wr.value;
      end
   end

   // Snapshot reads the bank before a write on the same edge lands,
   // so a write beside a sample only reaches the next sample
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         coef_snap_r <= '0;
      end else if (sample_valid) begin
         coef_snap_r <= coef_r;
      end
   end

   // One pulse per accepted sample
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ops_valid_r <= 1'b0;
      end else begin
         ops_valid_r <= sample_valid;
      end
   end

   // ==============================
   // Operand assembly
   // ==============================
   // Pure rewiring of registered state into the per-lane struct
   always_comb begin
      for (int c = 0; c < beam_pkg::num_channels; c++) begin
         ops[c].sample = window_r[c];
         ops[c].coef   = coef_snap_r[c];
      end
   end

   assign ops_valid = ops_valid_r;

endmodule

//--- verification/beam_checker.sv
/*
 * Beam valid checker
 * Bound into beam_top to watch the strobe-to-output timing
 */
module beam_checker (
   input logic clk,
   input logic rst,
   input logic sample_valid,
   input logic beam_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   // Cycles since reset release saturate at the pipeline depth
   int since_rst;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         since_rst <= 0;
      end else if (since_rst < beam_pkg::total_latency) begin
         since_rst <= since_rst + 1;
      end
   end

   // ==============================
   // Properties
   // ==============================
   // Pipeline still empty right after reset
   a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
      (since_rst < beam_pkg::total_latency) |-> !beam_valid)
      else $error("beam_valid high before the pipeline could fill");

   // Every strobe gives exactly one output total_latency cycles later
   a_strobe_to_beam: assert property (@(posedge clk) disable iff (rst)
      beam_valid == $past(sample_valid, beam_pkg::total_latency))
      else $error("beam_valid does not follow sample_valid by the pipeline latency");

endmodule

bind beam_top beam_checker u_checker (
   .clk          (clk),
   .rst          (rst),
   .sample_valid (sample_valid),
   .beam_valid   (beam_valid)
);

//--- verification/beam_tb.sv
/*
 * Beamformer testbench
 * Applies a table of coefficient writes, samples and idle cycles to beam_top
 * and checks every beam output against a reference model of the filter sum
 */
module beam_tb;
   timeunit 1ns;
   timeprecision 100ps;

   // One table row per clock cycle of stimulus
   // fixed marks rows whose beam value is worked out by hand
   typedef struct {
      bit                 smp_en;
      beam_pkg::sample_t  smp;
      bit                 wr_en;
      beam_pkg::coef_wr_t wr;
      bit                 fixed;
      beam_pkg::word_t    exp;
   } row_t;

   // DUT ports
   logic                            clk;
   logic                            rst;
   logic                            sample_valid;
   beam_pkg::sample_t               samples;
   logic                            coef_wr_valid;
   beam_pkg::coef_wr_t              coef_wr;
   logic [beam_pkg::data_width-1:0] beam;
   logic                            beam_valid;

   // Stimulus table and the outputs still awaited
   row_t            table_q[$];
   beam_pkg::word_t exp_q[$];
   int              cyc_q[$];

   // Reference model state with tap 0 as the newest sample
   beam_pkg::word_t model_hist [beam_pkg::num_channels][beam_pkg::num_taps] = '{default: '0};
   beam_pkg::word_t model_coef [beam_pkg::num_channels][beam_pkg::num_taps] = '{default: '0};

   int              errors;
   int              checked;
   int              cycles;
   int              limit;
   beam_pkg::word_t exp_beam;
   int              born;

   beam_top dut (
      .clk           (clk),
      .rst           (rst),
      .sample_valid  (sample_valid),
      .samples       (samples),
      .coef_wr_valid (coef_wr_valid),
      .coef_wr       (coef_wr),
      .beam          (beam),
      .beam_valid    (beam_valid)
   );

   // 40 ns clock
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // ==============================
   // Table building
   // ==============================
   function automatic beam_pkg::sample_t rand_samples();
      beam_pkg::sample_t s;
      for (int c = 0; c < beam_pkg::num_channels; c++) begin
         s.ch[c] = beam_pkg::word_t'($urandom);
      end
      return s;
   endfunction

   function automatic beam_pkg::sample_t fill_samples(beam_pkg::word_t value);
      beam_pkg::sample_t s;
      for (int c = 0; c < beam_pkg::num_channels; c++) begin
         s.ch[c] = value;
      end
      return s;
   endfunction

   function automatic beam_pkg::coef_wr_t make_write(int ch, int tap, beam_pkg::word_t value);
      beam_pkg::coef_wr_t w;
      w.channel = ch[beam_pkg::chan_idx_width-1:0];
      w.tap     = tap[beam_pkg::tap_idx_width-1:0];
      w.value   = value;
      return w;
   endfunction

   task automatic add_row(bit smp_en, beam_pkg::sample_t smp, bit wr_en,
                          beam_pkg::coef_wr_t wr, bit fixed, beam_pkg::word_t exp);
      row_t r;
      r = '{smp_en, smp, wr_en, wr, fixed, exp};
      table_q.push_back(r);
   endtask

   task automatic add_sample(beam_pkg::sample_t smp, bit fixed, beam_pkg::word_t exp);
      add_row(1'b1, smp, 1'b0, '0, fixed, exp);
   endtask

   task automatic add_write(int ch, int tap, beam_pkg::word_t value);
      add_row(1'b0, '0, 1'b1, make_write(ch, tap, value), 1'b0, '0);
   endtask

   task automatic add_idle();
      add_row(1'b0, '0, 1'b0, '0, 1'b0, '0);
   endtask

   task automatic build_table();
      beam_pkg::sample_t s;
      // All coefficients are still zero after reset and zero samples flush the window
      add_sample(rand_samples(), 1'b1, 16'h0000);
      add_sample(rand_samples(), 1'b1, 16'h0000);
      for (int i = 0; i < beam_pkg::num_taps; i++) begin
         add_sample(fill_samples('0), 1'b1, 16'h0000);
      end
      // Impulse on channel 0 with taps 1 to 4 while the other channels stay weighted zero
      for (int t = 0; t < beam_pkg::num_taps; t++) begin
         add_write(0, t, beam_pkg::word_t'(t + 1));
      end
      s = rand_samples();
      s.ch[0] = 16'h0001;
      add_sample(s, 1'b1, 16'h0001);
      for (int k = 2; k <= beam_pkg::num_taps + 1; k++) begin
         s = rand_samples();
         s.ch[0] = 16'h0000;
         add_sample(s, 1'b1, (k > beam_pkg::num_taps) ? 16'h0000 : beam_pkg::word_t'(k));
      end
      // Random bank followed by back-to-back random samples
      for (int c = 0; c < beam_pkg::num_channels; c++) begin
         for (int t = 0; t < beam_pkg::num_taps; t++) begin
            add_write(c, t, beam_pkg::word_t'($urandom));
         end
      end
      for (int i = 0; i < 12; i++) begin
         add_sample(rand_samples(), 1'b0, '0);
      end
      // Idle gaps of one to three cycles between strobes
      for (int i = 0; i < 8; i++) begin
         add_sample(rand_samples(), 1'b0, '0);
         repeat (i % 3 + 1) begin
            add_idle();
         end
      end
      // Full-scale operands where each product ffff*ffff wraps to 1
      for (int c = 0; c < beam_pkg::num_channels; c++) begin
         for (int t = 0; t < beam_pkg::num_taps; t++) begin
            add_write(c, t, 16'hffff);
         end
      end
      for (int i = 0; i < beam_pkg::num_taps - 1; i++) begin
         add_sample(fill_samples(16'hffff), 1'b0, '0);
      end
      add_sample(fill_samples(16'hffff), 1'b1, 16'h0010);
      // Write beside a sample costs only the next sample one product
      add_row(1'b1, fill_samples(16'hffff), 1'b1, make_write(2, 0, 16'h0000), 1'b1, 16'h0010);
      add_sample(fill_samples(16'hffff), 1'b1, 16'h000f);
      add_sample(fill_samples(16'h8000), 1'b0, '0);
   endtask

   // ==============================
   // Drive and reference model
   // ==============================
   task automatic apply_row(row_t r);
      logic [31:0] acc;
      sample_valid  = r.smp_en;
      samples       = r.smp;
      coef_wr_valid = r.wr_en;
      coef_wr       = r.wr;
      if (r.smp_en) begin
         acc = '0;
         for (int c = 0; c < beam_pkg::num_channels; c++) begin
            // History moves only on a strobe
            for (int t = beam_pkg::num_taps - 1; t > 0; t--) begin
               model_hist[c][t] = model_hist[c][t-1];
            end
            model_hist[c][0] = r.smp.ch[c];
            for (int t = 0; t < beam_pkg::num_taps; t++) begin
               acc = acc + 32'(model_hist[c][t]) * 32'(model_coef[c][t]);
            end
         end
         if (r.fixed) begin
            assert (acc[beam_pkg::data_width-1:0] == r.exp) else begin
               errors++;
               $display("reference model and hand-worked table value disagree at %0t", $time);
            end
         end
         exp_q.push_back(r.fixed ? r.exp : acc[beam_pkg::data_width-1:0]);
         cyc_q.push_back(cycles);
      end
      // Bank update after the sum so that a same-cycle sample sees the old value
      if (r.wr_en) begin
         model_coef[r.wr.channel][r.wr.tap] = r.wr.value;
      end
   endtask

   // ==============================
   // Output checks
   // ==============================
   // Sampled mid-cycle where the registered outputs are settled
   always @(negedge clk) begin
      if (!rst && beam_valid) begin
         assert (exp_q.size() != 0) else begin
            errors++;
            $display("beam output at %0t without any sample waiting for it", $time);
         end
         if (exp_q.size() != 0) begin
            exp_beam = exp_q.pop_front();
            born     = cyc_q.pop_front();
            checked++;
            assert (beam == exp_beam) else begin
               errors++;
               $display("error at %0t: beam expected %h actual %h", $time, exp_beam, beam);
            end
            assert (cycles - born == beam_pkg::total_latency) else begin
               errors++;
               $display("error at %0t: beam latency expected %0d actual %0d",
                        $time, beam_pkg::total_latency, cycles - born);
            end
         end
      end
   end

   // Cycle counter with run limit
   always @(posedge clk) begin
      if (!rst) begin
         cycles <= cycles + 1;
         if (cycles >= limit) begin
            $display("run stopped after %0d cycles with %0d beam outputs never seen",
                     cycles, exp_q.size());
            $display("checked %0d outputs, %0d errors", checked, errors + 1);
            $display("sim failed");
            $finish;
         end
      end
   end

   // ==============================
   // Main sequence
   // ==============================
   initial begin
      rst           = 1'b1;
      sample_valid  = 1'b0;
      samples       = '0;
      coef_wr_valid = 1'b0;
      coef_wr       = '0;
      errors        = 0;
      checked       = 0;
      cycles        = 0;
      limit         = 1000;
      void'($urandom(32'hce6d49cf));
      build_table();
      limit = table_q.size() + beam_pkg::total_latency + 20;
      repeat (4) @(posedge clk);
      #2 rst = 1'b0;
      foreach (table_q[i]) begin
         @(posedge clk);
         #2;
         apply_row(table_q[i]);
      end
      @(posedge clk);
      #2;
      sample_valid  = 1'b0;
      coef_wr_valid = 1'b0;
      // Drain the queue and watch for stray outputs
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (beam_pkg::total_latency) @(posedge clk);
      $display("checked %0d outputs, %0d errors", checked, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
